/* hdl/eth_tx_pkg.sv */
package eth_tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  buf_addr_t;
    typedef logic [8:0]  frame_len_t;
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] crc_t;

    // APB register map
    localparam apb_addr_t REG_CTRL   = 12'h000;
    localparam apb_addr_t REG_LEN    = 12'h004;
    localparam apb_addr_t REG_STATUS = 12'h008;
    localparam apb_addr_t BUF_BASE   = 12'h800;

    localparam int         BUF_DEPTH = 256;
    localparam frame_len_t MAX_LEN   = 9'd256;

    // Frame layout
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;
    localparam int    MIN_DATA_LEN  = 60;
    localparam int    FCS_LEN       = 4;
    localparam int    IFG_LEN       = 12;

    // Reflected IEEE 802.3 polynomial
    localparam crc_t CRC_POLY = 32'hEDB88320;
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DATA,
        PAD,
        FCS,
        GAP
    } tx_state_e;

endpackage

/* hdl/frame_ctrl_if.sv */
`timescale 1ns/1ps

interface frame_ctrl_if;
    import eth_tx_pkg::*;

    logic       start;
    frame_len_t len;
    logic       busy;
    logic       done;

    modport regs (
        output start,
        output len,
        input  busy,
        input  done
    );

    modport tx (
        input  start,
        input  len,
        output busy,
        output done
    );

endinterface

/* hdl/eth_crc32.sv */
`timescale 1ns/1ps

module eth_crc32 (
    input  logic              tx_clk_int,
    input  logic              rst_n,
    input  logic              init,
    input  logic              update,
    input  eth_tx_pkg::byte_t data,
    output eth_tx_pkg::crc_t  crc
);
    import eth_tx_pkg::*;

    crc_t crc_q;
    crc_t crc_next;

    // One byte, bit 0 first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data[i]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge tx_clk_int) begin
        if (!rst_n) begin
            crc_q <= CRC_INIT;
        end else if (init) begin
            crc_q <= CRC_INIT;
        end else if (update) begin
            crc_q <= crc_next;
        end
    end

    assign crc = ~crc_q;

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic                  tx_clk_int,
    input  eth_tx_pkg::buf_addr_t wr_addr,
    input  eth_tx_pkg::byte_t     wr_data,
    input  logic                  wr_en,
    input  eth_tx_pkg::buf_addr_t host_rd_addr,
    output eth_tx_pkg::byte_t     host_rd_data,
    input  eth_tx_pkg::buf_addr_t tx_rd_addr,
    output eth_tx_pkg::byte_t     tx_rd_data
);
    import eth_tx_pkg::*;

    byte_t mem [BUF_DEPTH];

    always_ff @(posedge tx_clk_int) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Host readback port
    always_ff @(posedge tx_clk_int) begin
        host_rd_data <= mem[host_rd_addr];
    end

    // Transmitter port, address one cycle ahead of use
    always_ff @(posedge tx_clk_int) begin
        tx_rd_data <= mem[tx_rd_addr];
    end

endmodule

/* hdl/apb_frame_regs.sv */
`timescale 1ns/1ps

module apb_frame_regs (
    input  logic                  tx_clk_int,
    input  logic                  rst_n,
    input  eth_tx_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  eth_tx_pkg::apb_data_t pwdata,
    output eth_tx_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output eth_tx_pkg::buf_addr_t buf_wr_addr,
    output eth_tx_pkg::byte_t     buf_wr_data,
    output logic                  buf_wr_en,
    output eth_tx_pkg::buf_addr_t buf_rd_addr,
    input  eth_tx_pkg::byte_t     buf_rd_data,
    frame_ctrl_if.regs            ctrl
);
    import eth_tx_pkg::*;

    logic       access;
    logic       sel_ctrl;
    logic       sel_len;
    logic       sel_status;
    logic       sel_buf;
    logic       tx_active;
    logic       start_req;
    logic       len_bad;
    logic       err;
    logic       wr_ok;
    logic       rd_wait;
    logic       start_q;
    frame_len_t len_q;
    logic [7:0] frame_cnt;

    assign access     = psel && penable;
    assign sel_ctrl   = (paddr == REG_CTRL);
    assign sel_len    = (paddr == REG_LEN);
    assign sel_status = (paddr == REG_STATUS);
    assign sel_buf    = (paddr[11:10] == BUF_BASE[11:10]);

    // Pulse already issued but not yet seen as busy
    assign tx_active = ctrl.busy || start_q;

    assign start_req = sel_ctrl && pwdata[0];
    assign len_bad   = (pwdata == '0) || (pwdata > apb_data_t'(MAX_LEN));
    assign err = pwrite && ((start_req && tx_active) || (sel_buf && tx_active) ||
                            (sel_len && len_bad));

    // Buffer reads wait one cycle for the registered port
    assign pready  = access && (!(sel_buf && !pwrite) || rd_wait);
    assign pslverr = pready && err;
    assign wr_ok   = access && pwrite && !err;

    assign buf_wr_addr = paddr[9:2];
    assign buf_wr_data = pwdata[7:0];
    assign buf_wr_en   = wr_ok && sel_buf;
    assign buf_rd_addr = paddr[9:2];

    assign ctrl.start = start_q;
    assign ctrl.len   = len_q;

    always_ff @(posedge tx_clk_int) begin
        if (!rst_n) begin
            rd_wait   <= 1'b0;
            start_q   <= 1'b0;
            len_q     <= frame_len_t'(MIN_DATA_LEN);
            frame_cnt <= '0;
        end else begin
            rd_wait <= access && sel_buf && !pwrite && !rd_wait;
            start_q <= wr_ok && start_req;
            if (wr_ok && sel_len) begin
                len_q <= pwdata[8:0];
            end
            if (ctrl.done) begin
                frame_cnt <= frame_cnt + 8'd1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (sel_len) begin
            prdata = apb_data_t'(len_q);
        end else if (sel_status) begin
            prdata = {16'h0000, frame_cnt, 7'd0, tx_active};
        end else if (sel_buf) begin
            prdata = apb_data_t'(buf_rd_data);
        end
    end

endmodule

/* hdl/gmii_frame_tx.sv */
`timescale 1ns/1ps

module gmii_frame_tx (
    input  logic                  tx_clk_int,
    input  logic                  rst_n,
    input  eth_tx_pkg::byte_t     rd_data,
    output eth_tx_pkg::buf_addr_t rd_addr,
    output eth_tx_pkg::byte_t     txd,
    output logic                  tx_en,
    frame_ctrl_if.tx              ctrl
);
    import eth_tx_pkg::*;

    tx_state_e  state;
    logic [8:0] cnt;
    frame_len_t len_q;
    logic       done_q;
    logic       crc_init;
    logic       crc_update;
    byte_t      crc_byte;
    crc_t       fcs;
    byte_t      fcs_byte;
    logic       last_data;

    assign crc_init   = (state == IDLE) && ctrl.start;
    assign crc_update = (state == DATA) || (state == PAD);
    // Padding bytes enter the CRC as zeros
    assign crc_byte   = (state == DATA) ? rd_data : '0;

    // Next byte requested while the current one goes out
    assign rd_addr = (state == DATA) ? buf_addr_t'(cnt + 9'd1) : '0;

    assign last_data = (cnt == len_q - 9'd1);
    assign fcs_byte  = fcs[{cnt[1:0], 3'b000} +: 8];

    assign ctrl.busy = (state != IDLE);
    assign ctrl.done = done_q;

    eth_crc32 u_crc (
        .tx_clk_int (tx_clk_int),
        .rst_n      (rst_n),
        .init       (crc_init),
        .update     (crc_update),
        .data       (crc_byte),
        .crc        (fcs)
    );

    always_ff @(posedge tx_clk_int) begin
        if (crc_init) begin
            len_q <= ctrl.len;
        end
    end

    always_ff @(posedge tx_clk_int) begin
        if (!rst_n) begin
            state  <= IDLE;
            cnt    <= '0;
            txd    <= '0;
            tx_en  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    txd   <= '0;
                    tx_en <= 1'b0;
                    cnt   <= '0;
                    if (ctrl.start) begin
                        state <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    txd   <= PREAMBLE_BYTE;
                    tx_en <= 1'b1;
                    cnt   <= cnt + 9'd1;
                    if (cnt == 9'(PREAMBLE_LEN - 1)) begin
                        state <= SFD;
                    end
                end
                SFD: begin
                    txd   <= SFD_BYTE;
                    tx_en <= 1'b1;
                    cnt   <= '0;
                    state <= DATA;
                end
                DATA: begin
                    txd   <= rd_data;
                    tx_en <= 1'b1;
                    cnt   <= cnt + 9'd1;
                    if (last_data) begin
                        // Short frames keep counting through the pad
                        if (len_q < frame_len_t'(MIN_DATA_LEN)) begin
                            state <= PAD;
                        end else begin
                            state <= FCS;
                            cnt   <= '0;
                        end
                    end
                end
                PAD: begin
                    txd   <= '0;
                    tx_en <= 1'b1;
                    cnt   <= cnt + 9'd1;
                    if (cnt == 9'(MIN_DATA_LEN - 1)) begin
                        state <= FCS;
                        cnt   <= '0;
                    end
                end
                FCS: begin
                    // Least significant byte first
                    txd   <= fcs_byte;
                    tx_en <= 1'b1;
                    cnt   <= cnt + 9'd1;
                    if (cnt == 9'(FCS_LEN - 1)) begin
                        state <= GAP;
                        cnt   <= '0;
                    end
                end
                GAP: begin
                    txd   <= '0;
                    tx_en <= 1'b0;
                    cnt   <= cnt + 9'd1;
                    if (cnt == 9'(IFG_LEN - 1)) begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/rgmii_tx_encoder.sv */
`timescale 1ns/1ps

module rgmii_tx_encoder (
    input  logic              tx_clk_int,
    input  logic              rst_n,
    input  eth_tx_pkg::byte_t txd,
    input  logic              tx_en,
    output logic [3:0]        td,
    output logic              tx_ctl
);
    import eth_tx_pkg::*;

    byte_t txd_q;
    logic  tx_en_q;

    // Output DDR stage, both halves loaded on the rising edge
    always_ff @(posedge tx_clk_int) begin
        if (!rst_n) begin
            txd_q   <= '0;
            tx_en_q <= 1'b0;
        end else begin
            txd_q   <= txd;
            tx_en_q <= tx_en;
        end
    end

    // Low nibble in the high phase, high nibble in the low phase
    assign td = tx_clk_int ? txd_q[3:0] : txd_q[7:4];

    // Second half would be tx_en xor tx_er, with no tx_er it is tx_en again
    assign tx_ctl = tx_en_q;

endmodule

/* hdl/eth_tx_top.sv */
`timescale 1ns/1ps

module eth_tx_top (
    input  logic                  tx_clk_int,
    input  logic                  rst_n,
    input  eth_tx_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  eth_tx_pkg::apb_data_t pwdata,
    output eth_tx_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [3:0]            td,
    output logic                  tx_ctl
);
    import eth_tx_pkg::*;

    buf_addr_t buf_wr_addr;
    byte_t     buf_wr_data;
    logic      buf_wr_en;
    buf_addr_t buf_rd_addr;
    byte_t     buf_rd_data;
    buf_addr_t tx_rd_addr;
    byte_t     tx_rd_data;
    byte_t     gmii_txd;
    logic      gmii_tx_en;

    frame_ctrl_if ctrl_if ();

    apb_frame_regs u_regs (
        .tx_clk_int  (tx_clk_int),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .buf_wr_en   (buf_wr_en),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .ctrl        (ctrl_if.regs)
    );

    frame_buffer u_buf (
        .tx_clk_int   (tx_clk_int),
        .wr_addr      (buf_wr_addr),
        .wr_data      (buf_wr_data),
        .wr_en        (buf_wr_en),
        .host_rd_addr (buf_rd_addr),
        .host_rd_data (buf_rd_data),
        .tx_rd_addr   (tx_rd_addr),
        .tx_rd_data   (tx_rd_data)
    );

    gmii_frame_tx u_tx (
        .tx_clk_int (tx_clk_int),
        .rst_n      (rst_n),
        .rd_data    (tx_rd_data),
        .rd_addr    (tx_rd_addr),
        .txd        (gmii_txd),
        .tx_en      (gmii_tx_en),
        .ctrl       (ctrl_if.tx)
    );

    rgmii_tx_encoder u_rgmii (
        .tx_clk_int (tx_clk_int),
        .rst_n      (rst_n),
        .txd        (gmii_txd),
        .tx_en      (gmii_tx_en),
        .td         (td),
        .tx_ctl     (tx_ctl)
    );

endmodule

/* bench/eth_tx_tb.sv */
`timescale 1ns/1ps

module eth_tx_tb;
    import eth_tx_pkg::*;

    localparam int          CLK_HALF      = 5;
    localparam int          NUM_FRAMES    = 11;
    localparam int          FRAME_CYCLES  = 8 + 256 + 4 + 12;
    localparam int          LOAD_CYCLES   = 4 * (256 + 2);
    localparam int          FRAME_TIMEOUT = FRAME_CYCLES + 100;
    localparam int          WATCHDOG_CYCLES =
        10 + 200 + NUM_FRAMES * (FRAME_CYCLES + LOAD_CYCLES) + 2000;
    localparam logic [31:0] SEED          = 32'hbf39a135;

    // 802.1D configuration BPDU, zero filled to 60 bytes
    localparam logic [0:479] BPDU = {
        80'h0180C20000_00000A3501,
        80'h0203002642_4203000000,
        80'h0000800000_0A35010203,
        80'h0000000080_00000A3501,
        80'h0203800100_0014000200,
        80'h0F00000000_0000000000
    };

    logic       tx_clk_int = 1'b0;
    logic       rst_n;
    apb_addr_t  paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic [3:0] td;
    logic       tx_ctl;

    byte_t payload [256];
    byte_t rx_bytes [$];
    int    rx_lens [$];
    int    rx_frames      = 0;
    int    frames_checked = 0;
    int    frames_sent    = 0;
    int    exp_len        = 0;
    int    err_count      = 0;
    int    tests_run      = 0;
    int    tests_failed   = 0;

    always #CLK_HALF tx_clk_int = ~tx_clk_int;

    eth_tx_top uut (
        .tx_clk_int (tx_clk_int),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .td         (td),
        .tx_ctl     (tx_ctl)
    );

    function automatic apb_addr_t buf_addr(input int idx);
        return BUF_BASE + apb_addr_t'(idx * 4);
    endfunction

    function automatic int frame_total(input int len);
        return 8 + ((len < 60) ? 60 : len) + 4;
    endfunction

    // CRC-32 over data plus zero padding, byte at a time
    function automatic crc_t frame_crc(input int len);
        crc_t  crc;
        byte_t b;
        int    data_len;
        data_len = (len < 60) ? 60 : len;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < data_len; i++) begin
            b = (i < len) ? payload[i] : 8'h00;
            crc = crc ^ {24'h0, b};
            for (int k = 0; k < 8; k++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    function automatic byte_t expected_byte(input int len, input int idx);
        int   data_len;
        int   pos;
        crc_t fcs;
        data_len = (len < 60) ? 60 : len;
        pos = idx - 8;
        if (idx < 7) begin
            return 8'h55;
        end
        if (idx == 7) begin
            return 8'hD5;
        end
        if (pos < len) begin
            return payload[pos];
        end
        if (pos < data_len) begin
            return 8'h00;
        end
        fcs = frame_crc(len);
        return fcs[(pos - data_len) * 8 +: 8];
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
        err_count++;
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err,
                              output logic first_ready);
        int waits;
        @(posedge tx_clk_int);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge tx_clk_int);
        penable <= 1'b1;
        @(negedge tx_clk_int);
        first_ready = pready;
        waits = 0;
        while (!pready && waits < 8) begin
            @(negedge tx_clk_int);
            waits++;
        end
        if (!pready) begin
            $display("ERROR: no pready within 8 cycles at address 0x%03h", addr);
            err_count++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge tx_clk_int);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused_data;
        logic      unused_ready;
        apb_access(1'b1, addr, data, unused_data, err, unused_ready);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err,
                            output logic first_ready);
        apb_access(1'b0, addr, '0, data, err, first_ready);
    endtask

    task automatic read_frame_count(output int cnt);
        apb_data_t data;
        logic      err;
        logic      rdy;
        apb_read(REG_STATUS, data, err, rdy);
        cnt = int'(data[15:8]);
    endtask

    task automatic load_frame(input int len);
        logic err;
        for (int i = 0; i < len; i++) begin
            apb_write(buf_addr(i), apb_data_t'(payload[i]), err);
            if (err !== 1'b0) value_error("pslverr", 0, err);
        end
        apb_write(REG_LEN, apb_data_t'(len), err);
        if (err !== 1'b0) value_error("pslverr", 0, err);
    endtask

    task automatic start_frame(input int len);
        logic err;
        exp_len = len;
        apb_write(REG_CTRL, 32'h1, err);
        if (err !== 1'b0) value_error("pslverr", 0, err);
        frames_sent++;
    endtask

    task automatic wait_frame(input int target);
        int cycles;
        cycles = 0;
        while (frames_checked < target && cycles < FRAME_TIMEOUT) begin
            @(posedge tx_clk_int);
            cycles++;
        end
        if (frames_checked < target) begin
            $display("ERROR: frame %0d did not appear on tx_ctl within %0d cycles",
                     target, FRAME_TIMEOUT);
            err_count++;
        end
    endtask

    task automatic wait_idle();
        apb_data_t data;
        logic      err;
        logic      rdy;
        int        polls;
        polls = 0;
        data = 32'h1;
        while (data[0] !== 1'b0 && polls < 40) begin
            apb_read(REG_STATUS, data, err, rdy);
            polls++;
        end
        if (data[0] !== 1'b0) begin
            $display("ERROR: STATUS busy still set after %0d polls", polls);
            err_count++;
        end
    endtask

    task automatic send_frame(input int len);
        load_frame(len);
        start_frame(len);
        wait_frame(frames_sent);
        wait_idle();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, err_count - errs_before);
        end
    endtask

    // Mid-phase sampling, as with a 90 degree shifted receive clock
    initial begin : rgmii_capture
        logic [3:0] lo;
        int         n;
        n = 0;
        forever begin
            @(posedge tx_clk_int);
            #2.5;
            if (tx_ctl === 1'b1) begin
                lo = td;
                @(negedge tx_clk_int);
                #2.5;
                rx_bytes.push_back({td, lo});
                n++;
            end else if (n > 0) begin
                rx_lens.push_back(n);
                n = 0;
                rx_frames++;
            end
        end
    end

    initial begin : frame_compare
        int    n;
        int    total;
        byte_t got;
        byte_t exp;
        forever begin
            wait (rx_frames > frames_checked);
            n = rx_lens.pop_front();
            total = frame_total(exp_len);
            if (n != total) value_error("frame_length", total, n);
            for (int i = 0; i < n; i++) begin
                got = rx_bytes.pop_front();
                if (i < total) begin
                    exp = expected_byte(exp_len, i);
                    if (got !== exp) begin
                        $display("[ERROR] frame_byte[%0d]: expected 0x%02h, got 0x%02h",
                                 i, exp, got);
                        err_count++;
                    end
                end
            end
            frames_checked++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("ERROR: simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : main_sequence
        apb_data_t data;
        logic      err;
        logic      rdy;
        int        errs;
        int        seed_ret;
        int        idx;
        int        len;
        int        cnt_before;
        int        cnt_after;
        byte_t     val;

        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        seed_ret = $urandom(SEED);
        repeat (10) @(posedge tx_clk_int);
        rst_n <= 1'b1;

        errs = err_count;
        apb_read(REG_STATUS, data, err, rdy);
        if (data !== 32'h0) value_error("prdata", 0, data);
        if (err !== 1'b0) value_error("pslverr", 0, err);
        repeat (50) @(posedge tx_clk_int);
        if (rx_frames != 0 || rx_bytes.size() != 0) begin
            $display("ERROR: tx_ctl went high with no frame started");
            err_count++;
        end
        apb_write(REG_LEN, 32'd100, err);
        if (err !== 1'b0) value_error("pslverr", 0, err);
        apb_read(REG_LEN, data, err, rdy);
        if (data !== 32'd100) value_error("prdata", 100, data);
        finish_test("reset state and LEN readback", errs);

        errs = err_count;
        for (int k = 0; k < 20; k++) begin
            idx = $urandom_range(0, 255);
            val = byte_t'($urandom_range(0, 255));
            apb_write(buf_addr(idx), apb_data_t'(val), err);
            if (err !== 1'b0) value_error("pslverr", 0, err);
            apb_read(buf_addr(idx), data, err, rdy);
            if (rdy !== 1'b0) value_error("pready", 0, rdy);
            if (data !== apb_data_t'(val)) value_error("prdata", val, data);
        end
        finish_test("buffer readback with wait state", errs);

        errs = err_count;
        for (int i = 0; i < 60; i++) begin
            payload[i] = BPDU[i * 8 +: 8];
        end
        send_frame(60);
        read_frame_count(cnt_after);
        if (cnt_after != 1) value_error("frame_count", 1, cnt_after);
        finish_test("BPDU frame", errs);

        // Buffer still holds BPDU bytes past 14, so padding must not use them
        errs = err_count;
        for (int i = 0; i < 14; i++) begin
            payload[i] = byte_t'($urandom_range(0, 255));
        end
        send_frame(14);
        finish_test("short frame padding", errs);

        errs = err_count;
        read_frame_count(cnt_before);
        for (int f = 0; f < 8; f++) begin
            len = $urandom_range(1, 256);
            for (int i = 0; i < len; i++) begin
                payload[i] = byte_t'($urandom_range(0, 255));
            end
            send_frame(len);
        end
        read_frame_count(cnt_after);
        if (cnt_after != ((cnt_before + 8) & 8'hFF)) begin
            value_error("frame_count", (cnt_before + 8) & 8'hFF, cnt_after);
        end
        finish_test("random frames", errs);

        errs = err_count;
        read_frame_count(cnt_before);
        for (int i = 0; i < 100; i++) begin
            payload[i] = byte_t'($urandom_range(0, 255));
        end
        load_frame(100);
        start_frame(100);
        apb_write(REG_CTRL, 32'h1, err);
        if (err !== 1'b1) value_error("pslverr", 1, err);
        apb_write(buf_addr(5), apb_data_t'(~payload[5]), err);
        if (err !== 1'b1) value_error("pslverr", 1, err);
        apb_write(REG_LEN, 32'd0, err);
        if (err !== 1'b1) value_error("pslverr", 1, err);
        apb_write(REG_LEN, 32'd300, err);
        if (err !== 1'b1) value_error("pslverr", 1, err);
        wait_frame(frames_sent);
        wait_idle();
        apb_read(REG_LEN, data, err, rdy);
        if (data !== 32'd100) value_error("prdata", 100, data);
        apb_read(buf_addr(5), data, err, rdy);
        if (data !== apb_data_t'(payload[5])) value_error("prdata", payload[5], data);
        read_frame_count(cnt_after);
        if (cnt_after != ((cnt_before + 1) & 8'hFF)) begin
            value_error("frame_count", (cnt_before + 1) & 8'hFF, cnt_after);
        end
        repeat (20) @(posedge tx_clk_int);
        if (rx_frames != frames_sent) value_error("frames_on_tx_ctl", frames_sent, rx_frames);
        finish_test("rejected accesses while busy", errs);

        $display("%0d tests run, %0d failing, %0d errors, %0d frames checked",
                 tests_run, tests_failed, err_count, frames_checked);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/eth_tx_pkg.sv
hdl/frame_ctrl_if.sv
hdl/eth_crc32.sv
hdl/frame_buffer.sv
hdl/apb_frame_regs.sv
hdl/gmii_frame_tx.sv
hdl/rgmii_tx_encoder.sv
hdl/eth_tx_top.sv
bench/eth_tx_tb.sv

/* Bender.yml */
package:
  name: eth_tx

sources:
  - hdl/eth_tx_pkg.sv
  - hdl/frame_ctrl_if.sv
  - hdl/eth_crc32.sv
  - hdl/frame_buffer.sv
  - hdl/apb_frame_regs.sv
  - hdl/gmii_frame_tx.sv
  - hdl/rgmii_tx_encoder.sv
  - hdl/eth_tx_top.sv
  - target: simulation
    files:
      - bench/eth_tx_tb.sv
